//--- design/icd2_pkg.sv
package icd2_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int ROW_CNT       = 4;     // scanline row buffers
  localparam int ROW_AW        = 9;     // 512 bytes per row buffer
  localparam int PAD_CNT       = 4;     // joypad registers 6004-6007
  localparam int PKT_BYTES     = 16;    // serial packet length
  localparam int PKT_BIT_W     = 7;     // bit position within the 128 bit packet

  // ----------------------------------------
  // pixel line limits
  // ----------------------------------------
  localparam int LINE_TILES    = 20;    // 160 pixels per line
  localparam int LAST_CHAR_ROW = 18;    // line advance stops here

  localparam logic [7:0] ICD2_VERSION = 8'h61; // read back at 600f

  // register selects decoded from the snes address
  typedef enum logic [3:0] {
    REG_LCDCHW,   // 6000 r
    REG_LCDCHR,   // 6001 w
    REG_PKTRDY,   // 6002 r
    REG_CTL,      // 6003 w
    REG_PAD0,     // 6004 w
    REG_PAD1,     // 6005 w
    REG_PAD2,     // 6006 w
    REG_PAD3,     // 6007 w
    REG_VER,      // 600f r
    REG_PKT,      // 7000-700f r
    REG_CHDAT,    // 7800 r
    REG_NONE
  } mmio_reg_e;

  // button and serial fsm
  typedef enum logic [1:0] {
    BTN_IDLE,
    BTN_RECV,
    BTN_WAIT
  } btn_state_e;

  typedef logic [PAD_CNT-1:0][7:0]   pad_bank_t;
  typedef logic [PKT_BYTES-1:0][7:0] pkt_bank_t;
  typedef logic [1:0]                row_sel_t;

endpackage

//--- design/icd2_mmio_regs.sv
`timescale 1ns/100ps

module icd2_mmio_regs (
  input  logic                        CLK,
  input  logic                        cpu_ireset_r,
  input  logic                        snes_rd_start,
  input  logic                        snes_wr_end,
  input  logic [23:0]                 snes_addr,
  input  logic [7:0]                  data_in,
  input  logic [7:0]                  lcdchw,
  input  logic [7:0]                  rd_data,
  input  icd2_pkg::pkt_bank_t         pkt,
  input  logic                        pktrdy,
  output logic [7:0]                  data_out,
  output logic                        cpu_rst,
  output icd2_pkg::row_sel_t          rd_row,
  output logic [icd2_pkg::ROW_AW-1:0] rd_index,
  output icd2_pkg::pad_bank_t         pads,
  output logic [1:0]                  player_mask,
  output logic                        pktrdy_clear
);

  import icd2_pkg::*;

  mmio_reg_e             reg_sel;
  row_sel_t              lcdchr_row_r;    // 6001 row select for read back
  logic                  ctl_run_r;       // 6003 bit 7, gb cpu out of reset
  logic [1:0]            ctl_players_r;   // 6003 bits 5:4
  pad_bank_t             pads_r;
  logic [7:0]            chdat_r;         // 7800 byte, trails rd_index by 2
  logic [ROW_AW-1:0]     rd_index_r;
  logic                  pktrdy_clear_r;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  // only bit 22, bits 15:11 and the low nibble take part
  always_comb begin
    reg_sel = REG_NONE;
    if (!snes_addr[22]) begin
      case (snes_addr[15:11])
        5'h0c: begin                             // 6000-67ff
          case (snes_addr[3:0])
            4'h0:    reg_sel = REG_LCDCHW;
            4'h1:    reg_sel = REG_LCDCHR;
            4'h2:    reg_sel = REG_PKTRDY;
            4'h3:    reg_sel = REG_CTL;
            4'h4:    reg_sel = REG_PAD0;
            4'h5:    reg_sel = REG_PAD1;
            4'h6:    reg_sel = REG_PAD2;
            4'h7:    reg_sel = REG_PAD3;
            4'hf:    reg_sel = REG_VER;
            default: reg_sel = REG_NONE;
          endcase
        end
        5'h0e:   reg_sel = REG_PKT;              // 7000-77ff, byte from nibble
        5'h0f:   reg_sel = (snes_addr[3:0] == 4'h0) ? REG_CHDAT : REG_NONE;
        default: reg_sel = REG_NONE;
      endcase
    end
  end

  // ----------------------------------------
  // register file
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      data_out       <= 8'h00;
      lcdchr_row_r   <= '0;
      ctl_run_r      <= 1'b0;                    // ctl resets to 8'h01, run bit low
      ctl_players_r  <= 2'b00;
      pads_r         <= '1;                      // no buttons pressed
      rd_index_r     <= '0;
      pktrdy_clear_r <= 1'b0;
    end else begin
      pktrdy_clear_r <= 1'b0;

      // reads latch early so later bus activity cannot disturb the byte
      if (snes_rd_start) begin
        case (reg_sel)
          REG_LCDCHW: data_out <= lcdchw;
          REG_PKTRDY: data_out <= {7'b0, pktrdy};
          REG_VER:    data_out <= ICD2_VERSION;
          REG_PKT: begin
            data_out <= pkt[snes_addr[3:0]];
            if (snes_addr[3:0] == 4'h0)
              pktrdy_clear_r <= 1'b1;            // reading byte 0 acks the packet
          end
          REG_CHDAT: begin
            data_out   <= chdat_r;
            rd_index_r <= rd_index_r + 1'b1;     // walk through the row
          end
          default: ;                             // write only or unmapped, hold
        endcase
      end

      if (snes_wr_end) begin
        case (reg_sel)
          REG_LCDCHR: begin
            lcdchr_row_r <= data_in[1:0];
            rd_index_r   <= '0;                  // restart read back at byte 0
          end
          REG_CTL: begin
            ctl_run_r     <= data_in[7];
            ctl_players_r <= data_in[5:4];
          end
          REG_PAD0, REG_PAD1, REG_PAD2, REG_PAD3:
            pads_r[snes_addr[1:0]] <= data_in;
          default: ;
        endcase
      end

      // disabled players always read as released
      case (ctl_players_r)
        2'b00:   pads_r[3:1] <= '1;              // one player
        2'b01:   pads_r[3:2] <= '1;              // two players
        default: ;                               // four players
      endcase
    end
  end

  // row buffer output registered once more for the 7800 port
  always_ff @(posedge CLK) begin
    chdat_r <= rd_data;
  end

  assign cpu_rst      = ~ctl_run_r;
  assign player_mask  = ctl_players_r;
  assign pads         = pads_r;
  assign rd_row       = lcdchr_row_r;
  assign rd_index     = rd_index_r;
  assign pktrdy_clear = pktrdy_clear_r;

  // bus accesses are spaced apart, so the ack to the serial side is one cycle
  a_clear_single: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    pktrdy_clear |=> !pktrdy_clear);

endmodule

//--- design/icd2_pixel_packer.sv
`timescale 1ns/100ps

module icd2_pixel_packer (
  input  logic                        CLK,
  input  logic                        cpu_ireset_r,
  input  logic                        ppu_dot_edge,
  input  logic                        ppu_pixel_valid,
  input  logic [1:0]                  ppu_pixel,
  input  logic                        ppu_vsync_edge,
  output logic [7:0]                  lcdchw,
  output icd2_pkg::row_sel_t          wr_row,
  output logic                        wr_en,
  output logic [icd2_pkg::ROW_AW-1:0] wr_addr,
  output logic [7:0]                  wr_data
);

  import icd2_pkg::*;

  logic [4:0]  tile_cnt_r;      // tiles packed on this line
  logic [2:0]  line_r;          // line within the character row
  logic [2:0]  pix_idx_r;       // pixel within the tile
  row_sel_t    row_idx_r;       // row buffer being filled
  logic [4:0]  char_row_r;
  logic [7:0]  plane0_r;        // low bit plane shifter
  logic [7:0]  plane1_r;        // high bit plane shifter
  logic [7:0]  wr_lo_r;         // finished plane 0 byte
  logic [7:0]  wr_hi_r;         // finished plane 1 byte
  logic [7:0]  wr_base_r;       // {tile, line} of the finished tile
  row_sel_t    wr_row_r;
  logic [1:0]  wr_pend_r;       // bit 0 writes plane 0, bit 1 writes plane 1

  logic        last_pix;
  logic        line_end;

  assign last_pix = ppu_dot_edge && ppu_pixel_valid && (pix_idx_r == 3'd7);
  assign line_end = ppu_dot_edge && (tile_cnt_r == 5'(LINE_TILES))
                    && (char_row_r != 5'(LAST_CHAR_ROW));

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      tile_cnt_r <= '0;
      line_r     <= '0;
      pix_idx_r  <= '0;
      row_idx_r  <= '0;
      char_row_r <= '0;
      wr_pend_r  <= '0;
    end else begin
      wr_pend_r <= {wr_pend_r[0], last_pix};     // two back to back writes

      if (ppu_dot_edge && ppu_pixel_valid) begin
        pix_idx_r <= pix_idx_r + 1'b1;
        if (last_pix)
          tile_cnt_r <= tile_cnt_r + 1'b1;
      end else if (ppu_vsync_edge) begin
        tile_cnt_r <= '0;                        // new frame starts at char row 0
        pix_idx_r  <= '0;
        char_row_r <= '0;
      end else if (line_end) begin
        // first empty dot after tile 19 moves to the next line
        tile_cnt_r <= '0;
        line_r     <= line_r + 1'b1;
        if (line_r == 3'd7) begin
          row_idx_r  <= row_idx_r + 1'b1;        // next buffer every 8 lines
          char_row_r <= char_row_r + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // planar packing
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (ppu_dot_edge && ppu_pixel_valid) begin
      plane0_r <= {plane0_r[6:0], ppu_pixel[0]}; // leftmost pixel ends in bit 7
      plane1_r <= {plane1_r[6:0], ppu_pixel[1]};
    end
    if (last_pix) begin
      // snapshot the tile so the next pixels cannot disturb the writes
      wr_lo_r   <= {plane0_r[6:0], ppu_pixel[0]};
      wr_hi_r   <= {plane1_r[6:0], ppu_pixel[1]};
      wr_base_r <= {tile_cnt_r, line_r};
      wr_row_r  <= row_idx_r;
    end
  end

  assign wr_en   = |wr_pend_r;
  assign wr_addr = {wr_base_r, wr_pend_r[1]};    // plane in the address lsb
  assign wr_data = wr_pend_r[1] ? wr_hi_r : wr_lo_r;
  assign wr_row  = wr_row_r;
  assign lcdchw  = {char_row_r, 1'b0, row_idx_r};

  // each tile yields exactly one plane pair
  a_wr_pair: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    wr_en ##1 wr_en |=> !wr_en);

endmodule

//--- design/icd2_row_buffers.sv
`timescale 1ns/100ps

module icd2_row_buffers (
  input  logic                        CLK,
  input  icd2_pkg::row_sel_t          wr_row,
  input  logic                        wr_en,
  input  logic [icd2_pkg::ROW_AW-1:0] wr_addr,
  input  logic [7:0]                  wr_data,
  input  icd2_pkg::row_sel_t          rd_row,
  input  logic [icd2_pkg::ROW_AW-1:0] rd_index,
  output logic [7:0]                  rd_data
);

  import icd2_pkg::*;

  logic [ROW_CNT-1:0][7:0] row_q;   // read port of every buffer
  row_sel_t                rd_row_q;

  // one simple dual port ram per scanline row
  for (genvar r = 0; r < ROW_CNT; r++) begin : g_row
    logic [7:0] mem [2**ROW_AW];
    logic [7:0] rd_q;

    always_ff @(posedge CLK) begin
      if (wr_en && (wr_row == row_sel_t'(r)))
        mem[wr_addr] <= wr_data;           // only the packer's current row
      rd_q <= mem[rd_index];
    end

    assign row_q[r] = rd_q;
  end

  // select follows the address stage
  always_ff @(posedge CLK) begin
    rd_row_q <= rd_row;
  end

  assign rd_data = row_q[rd_row_q];

endmodule

//--- design/icd2_joypad_link.sv
`timescale 1ns/100ps

module icd2_joypad_link (
  input  logic                 CLK,
  input  logic                 cpu_ireset_r,
  input  logic                 cpu_edge,
  input  logic [1:0]           p1i,
  input  icd2_pkg::pad_bank_t  pads,
  input  logic [1:0]           player_mask,
  input  logic                 pktrdy_clear,
  output logic [3:0]           p1o,
  output logic                 idl,
  output icd2_pkg::pkt_bank_t  pkt,
  output logic                 pktrdy
);

  import icd2_pkg::*;

  btn_state_e            state_r;
  btn_state_e            state_next_r;  // where WAIT goes on a good edge
  logic [1:0]            prev_r;        // p1i at the last cpu edge
  logic [1:0]            id_r;          // current player
  logic [PKT_BIT_W-1:0]  bit_pos_r;
  pkt_bank_t             pkt_r;
  logic                  pktrdy_r;
  logic [7:0]            pad_sel;

  // ----------------------------------------
  // button output
  // ----------------------------------------
  // 11 returns the inverted id, 01 the buttons, 10 the d-pad
  assign pad_sel = pads[id_r];
  assign p1o = (&p1i) ? ~{2'b00, id_r}
                      : (({4{p1i[1]}} | pad_sel[7:4]) & ({4{p1i[0]}} | pad_sel[3:0]));

  assign idl = (state_r == BTN_IDLE);   // no packet in flight

  // ----------------------------------------
  // serial fsm
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      state_r      <= BTN_IDLE;
      state_next_r <= BTN_IDLE;
      prev_r       <= 2'b11;            // lines idle high
      id_r         <= 2'b00;
      bit_pos_r    <= '0;
      pktrdy_r     <= 1'b0;
    end else begin
      if (pktrdy_clear)
        pktrdy_r <= 1'b0;               // snes read of 7000

      if (cpu_edge) begin
        prev_r <= p1i;

        if (p1i != prev_r) begin
          if (p1i == 2'b00) begin
            // reset pulse starts a packet from any state
            bit_pos_r    <= '0;
            state_next_r <= BTN_RECV;
            state_r      <= BTN_WAIT;
          end else begin
            case (state_r)
              BTN_IDLE: begin
                if ((prev_r == 2'b01) && p1i[1])
                  id_r <= (id_r + 1'b1) & player_mask; // wraps at player count
              end
              BTN_RECV: begin
                if (^p1i) begin         // 10 is a zero, 01 is a one
                  pkt_r[bit_pos_r[6:3]][bit_pos_r[2:0]] <= p1i[0];
                  bit_pos_r    <= bit_pos_r + 1'b1;
                  state_next_r <= (&bit_pos_r) ? BTN_IDLE : BTN_RECV;
                  state_r      <= BTN_WAIT;
                end
              end
              BTN_WAIT: begin
                if (state_next_r == BTN_IDLE) begin
                  if (p1i == 2'b10) begin
                    state_r  <= BTN_IDLE;   // stop bit closes the packet
                    pktrdy_r <= 1'b1;
                  end else if (p1i == 2'b01) begin
                    state_r  <= BTN_IDLE;   // bad stop bit
                  end
                end else if (p1i == 2'b11) begin
                  state_r <= state_next_r;  // release between bits
                end else begin
                  state_r <= BTN_IDLE;      // 10 or 01 without release aborts
                end
              end
              default: state_r <= BTN_IDLE;
            endcase
          end
        end
      end
    end
  end

  assign pkt    = pkt_r;
  assign pktrdy = pktrdy_r;

  a_state_legal: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    state_r inside {BTN_IDLE, BTN_RECV, BTN_WAIT});

endmodule

//--- design/icd2_top.sv
`timescale 1ns/100ps

module icd2_top (
  input  logic        CLK,
  input  logic        cpu_ireset_r,
  input  logic        cpu_edge,
  input  logic        snes_rd_start,
  input  logic        snes_wr_end,
  input  logic [23:0] snes_addr,
  input  logic [7:0]  data_in,
  input  logic        ppu_dot_edge,
  input  logic        ppu_pixel_valid,
  input  logic [1:0]  ppu_pixel,
  input  logic        ppu_vsync_edge,
  input  logic [1:0]  p1i,
  output logic [7:0]  data_out,
  output logic        cpu_rst,
  output logic [3:0]  p1o,
  output logic        idl
);

  import icd2_pkg::*;

  // ----------------------------------------
  // block interconnect
  // ----------------------------------------
  logic [7:0]         lcdchw;         // packer position for 6000
  row_sel_t           wr_row;
  logic               wr_en;
  logic [ROW_AW-1:0]  wr_addr;
  logic [7:0]         wr_data;
  row_sel_t           rd_row;         // 6001 read back select
  logic [ROW_AW-1:0]  rd_index;
  logic [7:0]         rd_data;
  pad_bank_t          pads;
  logic [1:0]         player_mask;
  logic               pktrdy_clear;
  pkt_bank_t          pkt;
  logic               pktrdy;

  icd2_mmio_regs icd2_mmio_regs_inst (
    .CLK           (CLK),
    .cpu_ireset_r  (cpu_ireset_r),
    .snes_rd_start (snes_rd_start),
    .snes_wr_end   (snes_wr_end),
    .snes_addr     (snes_addr),
    .data_in       (data_in),
    .lcdchw        (lcdchw),
    .rd_data       (rd_data),
    .pkt           (pkt),
    .pktrdy        (pktrdy),
    .data_out      (data_out),
    .cpu_rst       (cpu_rst),
    .rd_row        (rd_row),
    .rd_index      (rd_index),
    .pads          (pads),
    .player_mask   (player_mask),
    .pktrdy_clear  (pktrdy_clear)
  );

  icd2_pixel_packer icd2_pixel_packer_inst (
    .CLK             (CLK),
    .cpu_ireset_r    (cpu_ireset_r),
    .ppu_dot_edge    (ppu_dot_edge),
    .ppu_pixel_valid (ppu_pixel_valid),
    .ppu_pixel       (ppu_pixel),
    .ppu_vsync_edge  (ppu_vsync_edge),
    .lcdchw          (lcdchw),
    .wr_row          (wr_row),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data)
  );

  icd2_row_buffers icd2_row_buffers_inst (
    .CLK      (CLK),
    .wr_row   (wr_row),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_row   (rd_row),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  icd2_joypad_link icd2_joypad_link_inst (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .cpu_edge     (cpu_edge),
    .p1i          (p1i),
    .pads         (pads),
    .player_mask  (player_mask),
    .pktrdy_clear (pktrdy_clear),
    .p1o          (p1o),
    .idl          (idl),
    .pkt          (pkt),
    .pktrdy       (pktrdy)
  );

endmodule

//--- dv/icd2_tb.sv
`timescale 1ns/100ps

module icd2_tb;

  import icd2_pkg::*;

  // ----------------------------------------
  // cycle budgets, watchdog allows half again
  // ----------------------------------------
  localparam int BUDGET_RESET = 100;
  localparam int BUDGET_PADS  = 1200;
  localparam int BUDGET_PKT   = 900;
  localparam int BUDGET_ABORT = 100;
  localparam int BUDGET_PIXEL = 9000;
  localparam int WATCHDOG_CYCLES =
    (BUDGET_RESET + BUDGET_PADS + BUDGET_PKT + BUDGET_ABORT + BUDGET_PIXEL) * 3 / 2;

  logic        CLK = 1'b0;
  logic        cpu_ireset_r;
  logic        cpu_edge;
  logic        snes_rd_start;
  logic        snes_wr_end;
  logic [23:0] snes_addr;
  logic [7:0]  data_in;
  logic        ppu_dot_edge;
  logic        ppu_pixel_valid;
  logic [1:0]  ppu_pixel;
  logic        ppu_vsync_edge;
  logic [1:0]  p1i;
  logic [7:0]  data_out;
  logic        cpu_rst;
  logic [3:0]  p1o;
  logic        idl;

  integer      seed;
  int          err_cnt;
  int          test_err;                         // err_cnt when the test began
  int          pass_cnt;
  int          fail_cnt;
  logic [7:0]  rdata;
  logic [7:0]  v;

  // reference model state
  pad_bank_t            m_pads;
  logic [1:0]           m_mask;                  // ctl bits 5:4
  logic [127:0]         m_pkt_bits;              // packet, bit n of byte k at 8k+n
  logic                 m_pktrdy;
  btn_state_e           m_state;
  btn_state_e           m_next;
  logic [1:0]           m_prev;                  // p1i at the last cpu edge
  logic [1:0]           m_id;
  logic [PKT_BIT_W-1:0] m_bit;
  logic [7:0]           row_img [ROW_CNT][2**ROW_AW];
  logic [7:0]           m_plane0;
  logic [7:0]           m_plane1;
  logic [2:0]           m_pix;
  logic [4:0]           m_tile;
  logic [2:0]           m_line;
  row_sel_t             m_row;
  logic [4:0]           m_char;

  always #20 CLK = ~CLK;                         // 40 ns period

  icd2_top icd2_top_inst (
    .CLK             (CLK),
    .cpu_ireset_r    (cpu_ireset_r),
    .cpu_edge        (cpu_edge),
    .snes_rd_start   (snes_rd_start),
    .snes_wr_end     (snes_wr_end),
    .snes_addr       (snes_addr),
    .data_in         (data_in),
    .ppu_dot_edge    (ppu_dot_edge),
    .ppu_pixel_valid (ppu_pixel_valid),
    .ppu_pixel       (ppu_pixel),
    .ppu_vsync_edge  (ppu_vsync_edge),
    .p1i             (p1i),
    .data_out        (data_out),
    .cpu_rst         (cpu_rst),
    .p1o             (p1o),
    .idl             (idl)
  );

  // ----------------------------------------
  // snes bus
  // ----------------------------------------
  function automatic logic [23:0] reg_addr(mmio_reg_e sel, logic [3:0] sub);
    case (sel)
      REG_LCDCHW: return 24'h006000;
      REG_LCDCHR: return 24'h006001;
      REG_PKTRDY: return 24'h006002;
      REG_CTL:    return 24'h006003;
      REG_PAD0:   return 24'h006004 + sub;       // sub picks pad 0-3
      REG_VER:    return 24'h00600f;
      REG_PKT:    return 24'h007000 + sub;
      REG_CHDAT:  return 24'h007800;
      default:    return 24'h00ffff;
    endcase
  endfunction

  // strobes 6 cycles apart, returns at a falling edge
  task automatic bus_write(mmio_reg_e sel, logic [3:0] sub, logic [7:0] d);
    @(posedge CLK);
    snes_addr   <= reg_addr(sel, sub);
    data_in     <= d;
    snes_wr_end <= 1'b1;
    @(posedge CLK);
    snes_wr_end <= 1'b0;
    repeat (5) @(negedge CLK);
  endtask

  task automatic bus_read(mmio_reg_e sel, logic [3:0] sub, output logic [7:0] d);
    @(posedge CLK);
    snes_addr     <= reg_addr(sel, sub);
    snes_rd_start <= 1'b1;
    @(posedge CLK);
    snes_rd_start <= 1'b0;
    @(negedge CLK);
    d = data_out;                                // loaded one cycle after the strobe
    repeat (4) @(negedge CLK);
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_byte(string sig, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("error at %0t: %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  task automatic check_nibble(string sig, logic [3:0] exp, logic [3:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("error at %0t: %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  task automatic check_bit(string sig, logic exp, logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("error at %0t: %s expected %b actual %b", $time, sig, exp, act);
    end
  endtask

  task automatic finish_test(string name);
    if (err_cnt == test_err) begin
      pass_cnt++;
      $display("test %s finished, ok", name);
    end else begin
      fail_cnt++;
      $display("test %s finished, %0d mismatches", name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  // ----------------------------------------
  // joypad side and its model
  // ----------------------------------------
  function automatic logic pad_forced(int i);
    return (m_mask == 2'b00 && i >= 1) || (m_mask == 2'b01 && i >= 2);
  endfunction

  task automatic force_pads();
    for (int i = 0; i < PAD_CNT; i++)
      if (pad_forced(i))
        m_pads[i] = 8'hff;                       // player not enabled
  endtask

  function automatic logic [3:0] exp_p1o(logic [1:0] p);
    logic [3:0] nib;
    nib = 4'hf;
    if (p == 2'b11)
      nib = ~{2'b00, m_id};                      // id readout
    else begin
      if (!p[1])
        nib = nib & m_pads[m_id][7:4];
      if (!p[0])
        nib = nib & m_pads[m_id][3:0];
    end
    return nib;
  endfunction

  // one p1i value sampled on a cpu edge, model follows the fsm rules
  task automatic cpu_step(logic [1:0] p);
    @(posedge CLK);
    p1i      <= p;
    cpu_edge <= 1'b1;
    @(posedge CLK);
    cpu_edge <= 1'b0;
    @(negedge CLK);
    if (p != m_prev) begin
      if (p == 2'b00) begin
        m_bit   = '0;
        m_next  = BTN_RECV;
        m_state = BTN_WAIT;
      end else begin
        case (m_state)
          BTN_IDLE: begin
            if (m_prev == 2'b01 && p[1])
              m_id = (m_id + 1'b1) & m_mask;
          end
          BTN_RECV: begin
            if (p == 2'b01 || p == 2'b10) begin
              m_pkt_bits[m_bit] = p[0];          // lsb first in each byte
              m_next  = (m_bit == 7'd127) ? BTN_IDLE : BTN_RECV;
              m_bit   = m_bit + 1'b1;
              m_state = BTN_WAIT;
            end
          end
          default: begin
            if (m_next == BTN_IDLE && p == 2'b10) begin
              m_state  = BTN_IDLE;               // stop bit
              m_pktrdy = 1'b1;
            end else if (m_next == BTN_RECV && p == 2'b11)
              m_state = BTN_RECV;
            else if (p != 2'b11)
              m_state = BTN_IDLE;                // abort
          end
        endcase
      end
    end
    m_prev = p;
    check_bit("idl", m_state == BTN_IDLE, idl);  // idle flag tracks the fsm
  endtask

  // p1o is combinational, so no cpu edge here
  task automatic set_lines(logic [1:0] p);
    @(posedge CLK);
    p1i <= p;
    @(negedge CLK);
  endtask

  task automatic check_lines();
    set_lines(2'b11);
    check_nibble("p1o", exp_p1o(2'b11), p1o);
    set_lines(2'b01);
    check_nibble("p1o", exp_p1o(2'b01), p1o);
    set_lines(2'b10);
    check_nibble("p1o", exp_p1o(2'b10), p1o);
  endtask

  // ----------------------------------------
  // ppu side and its model
  // ----------------------------------------
  task automatic drive_dot(logic valid, logic [1:0] pix);
    @(posedge CLK);
    ppu_dot_edge    <= 1'b1;
    ppu_pixel_valid <= valid;
    ppu_pixel       <= pix;
    @(posedge CLK);
    ppu_dot_edge    <= 1'b0;
    ppu_pixel_valid <= 1'b0;
    if (valid) begin
      m_plane0 = {m_plane0[6:0], pix[0]};        // leftmost pixel in bit 7
      m_plane1 = {m_plane1[6:0], pix[1]};
      if (m_pix == 3'd7) begin
        row_img[m_row][{m_tile, m_line, 1'b0}] = m_plane0;
        row_img[m_row][{m_tile, m_line, 1'b1}] = m_plane1;
        m_tile = m_tile + 1'b1;
      end
      m_pix = m_pix + 1'b1;
    end else if (m_tile == LINE_TILES && m_char != LAST_CHAR_ROW) begin
      m_tile = '0;
      if (m_line == 3'd7) begin
        m_row  = m_row + 1'b1;
        m_char = m_char + 1'b1;
      end
      m_line = m_line + 1'b1;
    end
  endtask

  task automatic pulse_vsync();
    @(posedge CLK);
    ppu_vsync_edge <= 1'b1;
    @(posedge CLK);
    ppu_vsync_edge <= 1'b0;
    @(negedge CLK);
    m_tile = '0;
    m_pix  = '0;
    m_char = '0;
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // ----------------------------------------
  // tests
  // ----------------------------------------
  initial begin
    seed            = 32'h26a2_80aa;
    err_cnt         = 0;
    test_err        = 0;
    pass_cnt        = 0;
    fail_cnt        = 0;
    cpu_ireset_r    = 1'b1;
    cpu_edge        = 1'b0;
    snes_rd_start   = 1'b0;
    snes_wr_end     = 1'b0;
    snes_addr       = '0;
    data_in         = '0;
    ppu_dot_edge    = 1'b0;
    ppu_pixel_valid = 1'b0;
    ppu_pixel       = 2'b00;
    ppu_vsync_edge  = 1'b0;
    p1i             = 2'b11;                     // lines idle high
    m_pads          = '1;
    m_mask          = 2'b00;
    m_pkt_bits      = '0;
    m_pktrdy        = 1'b0;
    m_state         = BTN_IDLE;
    m_next          = BTN_IDLE;
    m_prev          = 2'b11;
    m_id            = 2'b00;
    m_bit           = '0;
    m_plane0        = '0;
    m_plane1        = '0;
    m_pix           = '0;
    m_tile          = '0;
    m_line          = '0;
    m_row           = '0;
    m_char          = '0;
    repeat (4) @(posedge CLK);
    cpu_ireset_r <= 1'b0;
    @(negedge CLK);

    // 1: reset values
    check_bit("idl", 1'b1, idl);
    check_bit("cpu_rst", 1'b1, cpu_rst);         // run bit clear
    bus_read(REG_VER, 4'h0, rdata);
    check_byte("data_out", 8'h61, rdata);
    bus_read(REG_PKTRDY, 4'h0, rdata);
    check_byte("data_out", 8'h00, rdata);
    finish_test("reset");

    // 2: ctl, pads and id cycling
    for (int r = 0; r < 8; r++) begin
      v = $random(seed);
      bus_write(REG_CTL, 4'h0, v);
      m_mask = v[5:4];
      force_pads();
      check_bit("cpu_rst", ~v[7], cpu_rst);
      for (int i = 0; i < PAD_CNT; i++) begin
        v = $random(seed);
        bus_write(REG_PAD0, i, v);
        m_pads[i] = pad_forced(i) ? 8'hff : v;
      end
      check_lines();                             // id may sit past the count
      for (int k = 0; k < 4; k++) begin
        cpu_step(2'b01);
        cpu_step(2'b11);                         // 01 to 1x moves to next id
        check_lines();
      end
    end
    bus_write(REG_CTL, 4'h0, 8'h30);             // four players
    m_mask = 2'b11;
    v = $random(seed) & 8'h7f;
    bus_write(REG_PAD0, 4'h3, v);
    m_pads[3] = v;
    for (int k = 0; k < 4 && m_id != 2'd3; k++) begin
      cpu_step(2'b01);
      cpu_step(2'b11);
    end
    bus_write(REG_CTL, 4'h0, 8'h00);             // back to one player, pad 3 released
    m_mask = 2'b00;
    force_pads();
    set_lines(2'b01);
    check_nibble("p1o", 4'hf, p1o);
    set_lines(2'b10);
    check_nibble("p1o", 4'hf, p1o);
    finish_test("joypad");

    // 3: full serial packet
    cpu_step(2'b00);                             // reset pulse opens the packet
    cpu_step(2'b11);
    check_bit("idl", 1'b0, idl);
    for (int b = 0; b < 8 * PKT_BYTES; b++) begin
      cpu_step(($random(seed) & 1) ? 2'b01 : 2'b10);
      cpu_step(2'b11);
    end
    cpu_step(2'b10);                             // stop bit
    check_bit("idl", 1'b1, idl);
    bus_read(REG_PKTRDY, 4'h0, rdata);
    check_byte("data_out", {7'b0, m_pktrdy}, rdata);
    for (int i = 0; i < PKT_BYTES; i++) begin
      bus_read(REG_PKT, i, rdata);
      if (i == 0)
        m_pktrdy = 1'b0;                         // byte 0 read acks the flag
      check_byte("data_out", m_pkt_bits[i*8 +: 8], rdata);
    end
    bus_read(REG_PKTRDY, 4'h0, rdata);
    check_byte("data_out", {7'b0, m_pktrdy}, rdata);
    finish_test("packet");

    // 4: aborted packet
    cpu_step(2'b00);
    cpu_step(2'b11);
    for (int b = 0; b < 3; b++) begin
      cpu_step(($random(seed) & 1) ? 2'b01 : 2'b10);
      cpu_step(2'b11);
    end
    check_bit("idl", 1'b0, idl);
    cpu_step(2'b10);
    cpu_step(2'b01);                             // no release in between
    check_bit("idl", 1'b1, idl);
    bus_read(REG_PKTRDY, 4'h0, rdata);
    check_byte("data_out", {7'b0, m_pktrdy}, rdata);
    finish_test("abort");

    // 5: pixel lines, read back through 7800
    for (int ln = 0; ln < 10; ln++) begin
      for (int d = 0; d < 8 * LINE_TILES; d++) begin
        if (($random(seed) & 3) == 0)
          drive_dot(1'b0, 2'b00);                // blank dot inside the line
        drive_dot(1'b1, $random(seed));
      end
      drive_dot(1'b0, 2'b00);                    // hblank dot advances the line
    end
    bus_read(REG_LCDCHW, 4'h0, rdata);
    check_byte("data_out", {m_char, 1'b0, m_row}, rdata);
    bus_write(REG_LCDCHR, 4'h0, 8'h00);
    for (int a = 0; a < 16 * LINE_TILES; a++) begin
      bus_read(REG_CHDAT, 4'h0, rdata);
      check_byte("data_out", row_img[0][a], rdata);
    end
    bus_write(REG_LCDCHR, 4'h0, 8'h01);          // row 1 holds lines 8 and 9
    for (int a = 0; a < 4; a++) begin
      bus_read(REG_CHDAT, 4'h0, rdata);
      check_byte("data_out", row_img[1][a], rdata);
    end
    pulse_vsync();
    bus_read(REG_LCDCHW, 4'h0, rdata);
    check_byte("data_out", {m_char, 1'b0, m_row}, rdata);
    finish_test("pixels");

    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- compile.f
design/icd2_pkg.sv
design/icd2_mmio_regs.sv
design/icd2_pixel_packer.sv
design/icd2_row_buffers.sv
design/icd2_joypad_link.sv
design/icd2_top.sv
dv/icd2_tb.sv

//--- Bender.yml
package:
  name: icd2

sources:
  # package first, then the blocks, then the top level
  - design/icd2_pkg.sv
  - design/icd2_mmio_regs.sv
  - design/icd2_pixel_packer.sv
  - design/icd2_row_buffers.sv
  - design/icd2_joypad_link.sv
  - design/icd2_top.sv
  - target: test
    files:
      - dv/icd2_tb.sv
